/* fp_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, exponent constants and operation codes
// for the pipelined floating-point multiplier
////////////////////////////////////////////////////////////

package fp_pkg;

	// Single-precision field widths
	localparam int exponent_width = 8;
	localparam int significand_width = 23;
	localparam int total_width = 1 + exponent_width + significand_width;

	// IEEE bias, sized to the exponent field so sums wrap mod 256
	localparam logic [exponent_width-1:0] exponent_bias = 127;

	// ITOF multiplier exponent
	// Integer magnitude is an unnormalized float with the point 23 bits up
	localparam logic [exponent_width-1:0] itof_exponent = 127 + 23;

	// Stage 1 to stage 2 operand width
	// ITOF passes a full 32-bit integer magnitude as the multiplier
	localparam int mul_operand_width = 32;

	// Full integer product of the two operands
	localparam int product_width = 2 * mul_operand_width;

	// Leading-one position of a 1.x times 1.x product with no carry out
	// Stage 3 adjusts the exponent by (lead - this)
	localparam logic [exponent_width-1:0] fmul_fraction_msb = 46;

	// Operation codes
	localparam int op_width = 6;
	localparam logic [op_width-1:0] op_fmul = 6'h22;
	localparam logic [op_width-1:0] op_itof = 6'h2a;

endpackage

/* fp_multiplier_stage1.sv */
////////////////////////////////////////////////////////////
// Multiplier stage 1: sign, exponent sum, hidden bits, ITOF prep
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_multiplier_stage1 (
	input  logic                                  clk,
	input  logic                                  reset_n,
	input  logic                                  in_valid,
	input  logic [fp_pkg::op_width-1:0]           operation,
	input  logic [fp_pkg::total_width-1:0]        operand1,
	input  logic [fp_pkg::total_width-1:0]        operand2,
	output logic                                  s1_valid,
	output logic [fp_pkg::mul_operand_width-1:0]  s1_multiplicand,
	output logic [fp_pkg::mul_operand_width-1:0]  s1_multiplier,
	output logic [fp_pkg::exponent_width-1:0]     s1_exponent,
	output logic                                  s1_sign,
	output logic                                  s1_zero
);

	logic                                is_itof;
	logic                                sign1;
	logic                                sign2;
	logic [fp_pkg::exponent_width-1:0]   exponent1;
	logic [fp_pkg::exponent_width-1:0]   exponent2;
	logic [fp_pkg::exponent_width-1:0]   unbiased1;
	logic [fp_pkg::exponent_width-1:0]   unbiased2;
	logic [fp_pkg::exponent_width-1:0]   result_exponent;
	logic                                result_zero;

	assign is_itof = (operation == fp_pkg::op_itof);

	// Multiplicand side
	always_comb
	begin
		if (is_itof)
		begin
			// Dummy 1.0 so ITOF reuses the multiply path
			sign1 = 1'b0;
			exponent1 = fp_pkg::exponent_bias;
			s1_multiplicand = {{(fp_pkg::mul_operand_width - fp_pkg::significand_width - 1){1'b0}},
				1'b1, {fp_pkg::significand_width{1'b0}}};
		end
		else
		begin
			sign1 = operand1[fp_pkg::total_width-1];
			exponent1 = operand1[fp_pkg::total_width-2 -: fp_pkg::exponent_width];
			// Hidden bit only for normal numbers, denormals fall to zero below
			s1_multiplicand = {{(fp_pkg::mul_operand_width - fp_pkg::significand_width - 1){1'b0}},
				exponent1 != '0, operand1[fp_pkg::significand_width-1:0]};
		end
	end

	// Multiplier side
	always_comb
	begin
		sign2 = operand2[fp_pkg::total_width-1];
		if (is_itof)
		begin
			// Two's complement magnitude, -2^31 stays 0x80000000 as unsigned
			exponent2 = fp_pkg::itof_exponent;
			s1_multiplier = sign2 ? -operand2 : operand2;
		end
		else
		begin
			exponent2 = operand2[fp_pkg::total_width-2 -: fp_pkg::exponent_width];
			s1_multiplier = {{(fp_pkg::mul_operand_width - fp_pkg::significand_width - 1){1'b0}},
				exponent2 != '0, operand2[fp_pkg::significand_width-1:0]};
		end
	end

	// Unbias, add, re-bias; all modulo the exponent field
	assign unbiased1 = exponent1 - fp_pkg::exponent_bias;
	assign unbiased2 = exponent2 - fp_pkg::exponent_bias;
	assign result_exponent = unbiased1 + unbiased2 + fp_pkg::exponent_bias;

	// ITOF is zero only for a zero integer
	assign result_zero = is_itof ? (operand2 == '0) : (exponent1 == '0 || exponent2 == '0);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			s1_valid <= 1'b0;
			s1_exponent <= '0;
			s1_sign <= 1'b0;
			s1_zero <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			s1_exponent <= result_exponent;
			s1_sign <= sign1 ^ sign2;
			s1_zero <= result_zero;
		end
	end

	// Only the two supported operations may enter the pipe
	a_legal_op: assert property (@(posedge clk) disable iff (!reset_n)
		in_valid |-> (operation == fp_pkg::op_fmul || operation == fp_pkg::op_itof));

endmodule

/* fp_multiplier_stage2.sv */
////////////////////////////////////////////////////////////
// Multiplier stage 2: registered significand product
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_multiplier_stage2 (
	input  logic                                  clk,
	input  logic                                  reset_n,
	input  logic                                  s1_valid,
	input  logic [fp_pkg::mul_operand_width-1:0]  s1_multiplicand,
	input  logic [fp_pkg::mul_operand_width-1:0]  s1_multiplier,
	input  logic [fp_pkg::exponent_width-1:0]     s1_exponent,
	input  logic                                  s1_sign,
	input  logic                                  s1_zero,
	output logic                                  s2_valid,
	output logic [fp_pkg::product_width-1:0]      s2_product,
	output logic [fp_pkg::exponent_width-1:0]     s2_exponent,
	output logic                                  s2_sign,
	output logic                                  s2_zero
);

	// Product of the combinational stage 1 operands
	// Taken at the same edge as exponent, sign and zero
	logic [fp_pkg::product_width-1:0]  s1_product;

	// Operands are combinational from the inputs of stage 1, so their
	// product is registered next to the stage 1 fields, then everything
	// moves on together one cycle later
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			s1_product <= '0;
			s2_valid <= 1'b0;
			s2_product <= '0;
			s2_exponent <= '0;
			s2_sign <= 1'b0;
			s2_zero <= 1'b0;
		end
		else
		begin
			s1_product <= s1_multiplicand * s1_multiplier;
			s2_valid <= s1_valid;
			s2_product <= s1_product;
			s2_exponent <= s1_exponent;
			s2_sign <= s1_sign;
			s2_zero <= s1_zero;
		end
	end

	// A nonzero operation must reach stage 3 with a nonzero product
	a_product_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
		(s1_valid && !s1_zero) |=> (s2_product != '0));

endmodule

/* fp_multiplier_stage3.sv */
////////////////////////////////////////////////////////////
// Multiplier stage 3: leading-one normalize, truncate, pack
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_multiplier_stage3 (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               s2_valid,
	input  logic [fp_pkg::product_width-1:0]   s2_product,
	input  logic [fp_pkg::exponent_width-1:0]  s2_exponent,
	input  logic                               s2_sign,
	input  logic                               s2_zero,
	output logic                               result_valid,
	output logic [fp_pkg::total_width-1:0]     result
);

	// Position of the top set bit, exponent wide so it adds directly
	logic [fp_pkg::exponent_width-1:0]     lead_pos;
	logic [fp_pkg::product_width-1:0]      normalized;
	logic [fp_pkg::significand_width-1:0]  fraction;
	logic [fp_pkg::exponent_width-1:0]     result_exponent;
	logic [fp_pkg::total_width-1:0]        packed_result;

	// Priority search, highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < fp_pkg::product_width; i++)
		begin
			if (s2_product[i])
				lead_pos = i[fp_pkg::exponent_width-1:0];
		end
	end

	// Move the leading one to the top bit
	assign normalized = s2_product << (fp_pkg::product_width - 1 - lead_pos);

	// Bits just below the leading one, the rest are dropped
	assign fraction = normalized[fp_pkg::product_width-2 -: fp_pkg::significand_width];

	// FMUL lands at 46 or 47; ITOF anywhere from 23 up
	// Wraps mod 256 and comes back into range for legal results
	assign result_exponent = s2_exponent + lead_pos - fp_pkg::fmul_fraction_msb;

	always_comb
	begin
		if (s2_zero || s2_product == '0)
		begin
			// Signed zero
			packed_result = {s2_sign, {(fp_pkg::total_width - 1){1'b0}}};
		end
		else
		begin
			packed_result = {s2_sign, result_exponent, fraction};
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			result_valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			result_valid <= s2_valid;
			result <= packed_result;
		end
	end

	// Valid must stay known through the whole pipe once out of reset
	a_valid_known: assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown(result_valid));

endmodule

/* fp_multiplier.sv */
////////////////////////////////////////////////////////////
// Three-stage FMUL/ITOF pipeline top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_multiplier (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            in_valid,
	input  logic [fp_pkg::op_width-1:0]     operation,
	input  logic [fp_pkg::total_width-1:0]  operand1,
	input  logic [fp_pkg::total_width-1:0]  operand2,
	output logic                            result_valid,
	output logic [fp_pkg::total_width-1:0]  result
);

	// Stage 1 to stage 2
	logic                                  s1_valid;
	logic [fp_pkg::mul_operand_width-1:0]  s1_multiplicand;
	logic [fp_pkg::mul_operand_width-1:0]  s1_multiplier;
	logic [fp_pkg::exponent_width-1:0]     s1_exponent;
	logic                                  s1_sign;
	logic                                  s1_zero;

	// Stage 2 to stage 3
	logic                                  s2_valid;
	logic [fp_pkg::product_width-1:0]      s2_product;
	logic [fp_pkg::exponent_width-1:0]     s2_exponent;
	logic                                  s2_sign;
	logic                                  s2_zero;

	fp_multiplier_stage1 u_stage1 (
		.clk             (clk),
		.reset_n         (reset_n),
		.in_valid        (in_valid),
		.operation       (operation),
		.operand1        (operand1),
		.operand2        (operand2),
		.s1_valid        (s1_valid),
		.s1_multiplicand (s1_multiplicand),
		.s1_multiplier   (s1_multiplier),
		.s1_exponent     (s1_exponent),
		.s1_sign         (s1_sign),
		.s1_zero         (s1_zero)
	);

	// Product register, lines operands up with stage 1 fields
	fp_multiplier_stage2 u_stage2 (
		.clk             (clk),
		.reset_n         (reset_n),
		.s1_valid        (s1_valid),
		.s1_multiplicand (s1_multiplicand),
		.s1_multiplier   (s1_multiplier),
		.s1_exponent     (s1_exponent),
		.s1_sign         (s1_sign),
		.s1_zero         (s1_zero),
		.s2_valid        (s2_valid),
		.s2_product      (s2_product),
		.s2_exponent     (s2_exponent),
		.s2_sign         (s2_sign),
		.s2_zero         (s2_zero)
	);

	fp_multiplier_stage3 u_stage3 (
		.clk          (clk),
		.reset_n      (reset_n),
		.s2_valid     (s2_valid),
		.s2_product   (s2_product),
		.s2_exponent  (s2_exponent),
		.s2_sign      (s2_sign),
		.s2_zero      (s2_zero),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// Testbench clock and power-on reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Release just after a rising edge, away from the next one
	initial
	begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2 reset_n = 1'b1;
	end

endmodule

/* fp_multiplier_tb.sv */
////////////////////////////////////////////////////////////
// FMUL/ITOF pipeline testbench: table, random phase, model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_multiplier_tb;

	localparam int table_length = 15;
	localparam int random_count = 200;
	localparam int entry_width = fp_pkg::op_width + 3 * fp_pkg::total_width;

	// Columns: operation, operand1, operand2, expected result
	localparam logic [entry_width-1:0] vectors [table_length] = '{
		{fp_pkg::op_fmul, 32'h3fc00000, 32'h40000000, 32'h40400000},  // 1.5 x 2.0
		{fp_pkg::op_fmul, 32'hc0400000, 32'h3f000000, 32'hbfc00000},  // -3.0 x 0.5
		{fp_pkg::op_fmul, 32'h3fa00000, 32'h3fa00000, 32'h3fc80000},  // 1.25 x 1.25, no shift
		{fp_pkg::op_fmul, 32'h3fc00000, 32'h3fc00000, 32'h40100000},  // 1.5 x 1.5, one-bit shift
		{fp_pkg::op_fmul, 32'h3f800000, 32'h3f800000, 32'h3f800000},
		{fp_pkg::op_fmul, 32'h3f800001, 32'h3f800001, 32'h3f800002},  // 2^-46 term dropped
		{fp_pkg::op_fmul, 32'h00000000, 32'h40a00000, 32'h00000000},
		{fp_pkg::op_fmul, 32'h80000000, 32'h40000000, 32'h80000000},
		{fp_pkg::op_fmul, 32'h00000001, 32'hbf800000, 32'h80000000},  // Denormal
		{fp_pkg::op_fmul, 32'hc0000000, 32'h80400000, 32'h00000000},
		{fp_pkg::op_itof, 32'h00000000, 32'h00000000, 32'h00000000},
		{fp_pkg::op_itof, 32'h00000000, 32'h00000001, 32'h3f800000},
		{fp_pkg::op_itof, 32'h00000000, 32'hffffffff, 32'hbf800000},
		{fp_pkg::op_itof, 32'h00000000, 32'h01000001, 32'h4b800000},  // Low bit truncated
		{fp_pkg::op_itof, 32'h00000000, 32'h80000000, 32'hcf000000}
	};

	logic                            clk;
	logic                            reset_n;
	logic                            in_valid;
	logic [fp_pkg::op_width-1:0]     operation;
	logic [fp_pkg::total_width-1:0]  operand1;
	logic [fp_pkg::total_width-1:0]  operand2;
	logic                            result_valid;
	logic [fp_pkg::total_width-1:0]  result;

	logic [31:0] lfsr_state = 32'ha28a4e42;
	int edge_count = 0;
	int results_seen = 0;
	// Expected words and output edges, in issue order
	logic [fp_pkg::total_width-1:0] expected_results [$];
	int expected_edges [$];

	tb_clock_gen #(.period_ns(40), .reset_cycles(2)) u_clock_gen (
		.clk     (clk),
		.reset_n (reset_n)
	);

	fp_multiplier i_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.in_valid     (in_valid),
		.operation    (operation),
		.operand1     (operand1),
		.operand2     (operand2),
		.result_valid (result_valid),
		.result       (result)
	);

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Galois LFSR step, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	// Exponent 64..190 keeps the product in range; 1 in 16 gets a zero exponent
	function automatic logic [31:0] random_float();
		logic [31:0] sign_bit;
		logic [31:0] exponent;
		logic [31:0] fraction;
		sign_bit = random_bits(1);
		exponent = 64 + random_bits(7) % 127;
		if (random_bits(4) == 0)
			exponent = 0;
		fraction = random_bits(23);
		return {sign_bit[0], exponent[7:0], fraction[22:0]};
	endfunction

	// Expected word from the FMUL and ITOF result rules
	function automatic logic [31:0] model_result(input logic [fp_pkg::op_width-1:0] op,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] product;
		logic [54:0] wide;
		logic [31:0] magnitude;
		logic [22:0] fraction;
		int lead;
		int exponent;
		lead = 0;
		if (op == fp_pkg::op_itof)
		begin
			if (b == 0)
				return 32'h0;
			magnitude = b[31] ? (~b + 1) : b;
			for (int i = 0; i < 32; i++)
			begin
				if (magnitude[i])
					lead = i;
			end
			// Top bit lands on bit 23, the fraction is what sits below it
			wide = {magnitude, 23'b0} >> lead;
			exponent = 127 + lead;
			return {b[31], exponent[7:0], wide[22:0]};
		end
		if (a[30:23] == 0 || b[30:23] == 0)
			return {a[31] ^ b[31], 31'h0};
		product = {40'h0, 1'b1, a[22:0]} * {40'h0, 1'b1, b[22:0]};
		for (int i = 0; i < 64; i++)
		begin
			if (product[i])
				lead = i;
		end
		exponent = int'(a[30:23]) + int'(b[30:23]) - 127 + lead - 46;
		fraction = product[lead-1 -: 23];
		return {a[31] ^ b[31], exponent[7:0], fraction};
	endfunction

	task automatic issue_operation(input logic [fp_pkg::op_width-1:0] op,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] expected);
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		operation = op;
		operand1 = a;
		operand2 = b;
		expected_results.push_back(expected);
		// Sampled at the next edge, result registered two edges after that
		expected_edges.push_back(edge_count + 3);
	endtask

	// Idle cycle with garbage operands that must not leak into results
	task automatic idle_cycle();
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		operand1 = random_bits(32);
		operand2 = random_bits(32);
	endtask

	always @(posedge clk)
		edge_count <= edge_count + 1;

	// Outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (reset_n && result_valid)
		begin
			if (expected_results.size() == 0)
			begin
				$display("Error at %0t: result_valid high with no operation in flight", $time);
				stop_with_failure();
			end
			else
			begin
				check_value("result_valid edge", expected_edges.pop_front(), edge_count);
				check_value("result", expected_results.pop_front(), result);
				results_seen = results_seen + 1;
			end
		end
	end

	// At most two cycles per operation, plus reset, drain and margin
	initial
	begin
		#((2 + table_length + 2 * random_count + 50) * 40);
		$display("Error: watchdog expired before all results arrived");
		stop_with_failure();
	end

	initial
	begin
		logic [fp_pkg::op_width-1:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expected;
		in_valid = 1'b0;
		operation = fp_pkg::op_fmul;
		operand1 = '0;
		operand2 = '0;
		@(posedge reset_n);
		// Quiet pipe after reset, the monitor flags any early valid
		repeat (3) @(posedge clk);
		for (int i = 0; i < table_length; i++)
		begin
			{op, a, b, expected} = vectors[i];
			check_value("model against table", expected, model_result(op, a, b));
			issue_operation(op, a, b, expected);
		end
		for (int i = 0; i < random_count; i++)
		begin
			if (random_bits(3) == 0)
				idle_cycle();
			if (random_bits(1) == 1)
			begin
				op = fp_pkg::op_itof;
				a = random_bits(32);
				b = random_bits(32);
			end
			else
			begin
				op = fp_pkg::op_fmul;
				a = random_float();
				b = random_float();
			end
			issue_operation(op, a, b, model_result(op, a, b));
		end
		idle_cycle();
		while (expected_results.size() != 0)
			@(negedge clk);
		// Catch a stray valid after the last result
		repeat (4) @(negedge clk);
		if (results_seen != table_length + random_count)
		begin
			$display("Error: %0d results seen, %0d issued", results_seen,
				table_length + random_count);
			stop_with_failure();
		end
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* build.f */
fp_pkg.sv
fp_multiplier_stage1.sv
fp_multiplier_stage2.sv
fp_multiplier_stage3.sv
fp_multiplier.sv
tb_clock_gen.sv
fp_multiplier_tb.sv

/* Makefile */
TOP := fp_multiplier_tb

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f $(shell cat build.f)
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
